//--- llspi_cmd_pkg.sv
package llspi_cmd_pkg;

	// one host command word, control or data
	localparam int CMD_W = 9;
	// control bits held by the serializer after a control word
	localparam int CTL_W = 6;

	// bit positions inside ctl_bits
	localparam int CTL_READ_EN = 5;
	localparam int CTL_ADC_READ = 4;

	// serializer states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_LOAD = 2'd1;
	localparam logic [1:0] ST_SHIFT = 2'd2;

	// msb picks the view, 1 for control and 0 for data
	typedef union packed {
		struct packed {
			logic       kind;
			logic [1:0] pad;
			logic       read_en;
			logic       adc_read;
			logic       spare;
			logic [2:0] dev_sel;
		} ctl;
		struct packed {
			logic       kind;
			logic [7:0] payload;
		} data;
	} llspi_cmd_t;

endpackage

//--- llspi_board_pkg.sv
package llspi_board_pkg;

	// dev_sel codes, one per board device
	// ADC_BOTH selects both AD9653 parts at once, used for sync tests
	// AMC and SDC sit on the isolated poll bus
	localparam logic [2:0] DEV_NONE = 3'd0, DEV_LMK = 3'd1, DEV_ADC0 = 3'd2,
		DEV_ADC1 = 3'd3, DEV_DAC = 3'd4, DEV_ADC_BOTH = 3'd5, DEV_AMC = 3'd6,
		DEV_SDC = 3'd7;

	// result queue depth is 16 words
	// the status nibble wraps beyond that
	localparam int RESULT_AW = 4;

	// command queue depth, 32 words by default
	localparam int CMD_AW_DEFAULT = 5;

	// default serial pace, one tick per 64 clocks
	// slow enough for every part on the board
	localparam int PACE_BITS_DEFAULT = 6;

endpackage

//--- spi_word_fifo.sv
`timescale 1ns/1ps

module spi_word_fifo #(
	parameter int dw = 8,
	parameter int aw = 4
) (
	input  logic          clk,
	input  logic          arst_n,
	input  logic          we,
	input  logic [dw-1:0] din,
	input  logic          re,
	output logic [dw-1:0] dout,
	output logic          full,
	output logic          empty,
	output logic [aw:0]   count
);

	// word storage
	logic [dw-1:0] mem [2**aw];

	// pointers carry one extra wrap bit
	logic [aw:0] wr_ptr;
	logic [aw:0] rd_ptr;

	logic push;
	logic pop;

	// writes into a full queue and reads of an empty one are ignored
	assign push = we && !full;
	assign pop = re && !empty;

	// same index, different wrap bit means full
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]) && (wr_ptr[aw] != rd_ptr[aw]);
	assign count = wr_ptr - rd_ptr;

	// show-ahead, head word is valid while empty is low
	assign dout = mem[rd_ptr[aw-1:0]];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[aw-1:0]] <= din;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

//--- spi_eater.sv
`timescale 1ns/1ps

module spi_eater #(
	parameter int pace_bits = 6
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  llspi_cmd_pkg::llspi_cmd_t       cmd_data,
	input  logic                            cmd_empty,
	output logic                            pull,
	input  logic                            miso,
	output logic                            sclk,
	output logic                            mosi,
	output logic [llspi_cmd_pkg::CTL_W-1:0] ctl_bits,
	output logic                            result_we,
	output logic [7:0]                      result
);

	import llspi_cmd_pkg::*;

	logic [pace_bits-1:0] pace_cnt;
	logic tick;
	logic [1:0] state;
	// counts the 16 half-bit ticks of a byte
	logic [3:0] tick_cnt;
	logic rise_tick;
	logic fall_tick;
	logic last_tick;
	logic [7:0] tx_sr;
	logic [7:0] rx_sr;

	// free-running pace, tick lasts one clock every 2^pace_bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pace_cnt <= '0;
		end else begin
			pace_cnt <= pace_cnt + 1'b1;
		end
	end

	assign tick = &pace_cnt;

	// even tick_cnt raises sclk, odd one drops it
	assign rise_tick = (state == ST_SHIFT) && tick && !tick_cnt[0];
	assign fall_tick = (state == ST_SHIFT) && tick && tick_cnt[0];
	assign last_tick = fall_tick && (&tick_cnt);

	// accept the head word whenever idle, queue is show-ahead
	assign pull = (state == ST_IDLE) && !cmd_empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			ctl_bits <= '0;
			sclk <= 1'b0;
			mosi <= 1'b0;
			result_we <= 1'b0;
			tick_cnt <= '0;
		end else begin
			result_we <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (pull) begin
						// control words finish here, ctl_bits shows up next cycle
						if (cmd_data.ctl.kind) begin
							ctl_bits <= {cmd_data.ctl.read_en, cmd_data.ctl.adc_read,
								cmd_data.ctl.spare, cmd_data.ctl.dev_sel};
						end else begin
							state <= ST_LOAD;
						end
					end
				end
				ST_LOAD: begin
					// present msb ahead of the first rise
					mosi <= tx_sr[7];
					tick_cnt <= '0;
					state <= ST_SHIFT;
				end
				ST_SHIFT: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					if (rise_tick) begin
						sclk <= 1'b1;
					end
					if (fall_tick) begin
						sclk <= 1'b0;
						// next bit, or park low after the eighth
						mosi <= last_tick ? 1'b0 : tx_sr[6];
					end
					if (last_tick) begin
						result_we <= ctl_bits[CTL_READ_EN];
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// byte shifters
	always_ff @(posedge clk) begin
		if (pull && !cmd_data.data.kind) begin
			tx_sr <= cmd_data.data.payload;
		end else if (fall_tick) begin
			tx_sr <= {tx_sr[6:0], 1'b0};
		end
		// miso sampled at each sclk rise, msb first
		if (rise_tick) begin
			rx_sr <= {rx_sr[6:0], miso};
		end
		if (last_tick) begin
			result <= rx_sr;
		end
	end

endmodule

//--- spi_pin_mux.sv
`timescale 1ns/1ps

module spi_pin_mux (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            sclk,
	input  logic                            mosi,
	input  logic [llspi_cmd_pkg::CTL_W-1:0] ctl_bits,
	output logic                            P2_SCLK,
	output logic                            P2_SDI,
	output logic                            P2_LMK_LEuWire,
	output logic                            P2_ADC_SDIO_DIR,
	output logic                            P2_ADC_CSB_0,
	output logic                            P2_ADC_CSB_1,
	output logic                            P2_DAC_CSB,
	output logic                            P2_POLL_SCLK,
	output logic                            P2_POLL_MOSI,
	output logic                            P2_AMC7823_SPI_SS,
	output logic                            P2_AD7794_CSb,
	input  logic                            P2_DAC_SDO,
	input  logic                            P2_AMC7823_SPI_MISO,
	input  logic                            P2_AD7794_DOUT,
	input  logic                            sdi,
	output logic                            sdo,
	output logic                            sdio_drive,
	output logic                            miso
);

	import llspi_cmd_pkg::*;
	import llspi_board_pkg::*;

	logic [2:0] dev_sel;
	logic adc_sel;
	logic poll_sel;
	// registered miso sources
	logic adc_grab;
	logic dac_grab;
	logic amc_grab;
	logic sdc_grab;

	assign dev_sel = ctl_bits[2:0];
	assign adc_sel = (dev_sel == DEV_ADC0) || (dev_sel == DEV_ADC1) ||
		(dev_sel == DEV_ADC_BOTH);
	// poll parts get their own clock and data lines, kept quiet otherwise
	assign poll_sel = (dev_sel == DEV_AMC) || (dev_sel == DEV_SDC);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			P2_SCLK <= 1'b0;
			P2_SDI <= 1'b0;
			P2_POLL_SCLK <= 1'b0;
			P2_POLL_MOSI <= 1'b0;
			P2_ADC_SDIO_DIR <= 1'b1;
			sdo <= 1'b0;
			sdio_drive <= 1'b1;
			P2_LMK_LEuWire <= 1'b1;
			P2_ADC_CSB_0 <= 1'b1;
			P2_ADC_CSB_1 <= 1'b1;
			P2_DAC_CSB <= 1'b1;
			P2_AMC7823_SPI_SS <= 1'b1;
			P2_AD7794_CSb <= 1'b1;
		end else begin
			P2_SCLK <= sclk & ~poll_sel;
			P2_SDI <= mosi & ~poll_sel;
			P2_POLL_SCLK <= sclk & poll_sel;
			P2_POLL_MOSI <= mosi & poll_sel;
			// adc read turns the sdio pin around
			P2_ADC_SDIO_DIR <= ~ctl_bits[CTL_ADC_READ];
			sdio_drive <= ~ctl_bits[CTL_ADC_READ];
			sdo <= mosi & adc_sel;
			// active-low selects
			P2_LMK_LEuWire <= (dev_sel != DEV_LMK);
			P2_ADC_CSB_0 <= (dev_sel != DEV_ADC0) && (dev_sel != DEV_ADC_BOTH);
			P2_ADC_CSB_1 <= (dev_sel != DEV_ADC1) && (dev_sel != DEV_ADC_BOTH);
			P2_DAC_CSB <= (dev_sel != DEV_DAC);
			P2_AMC7823_SPI_SS <= (dev_sel != DEV_AMC);
			P2_AD7794_CSb <= (dev_sel != DEV_SDC);
		end
	end

	// input flops, two clocks of slack against the sampling rise
	always_ff @(posedge clk) begin
		adc_grab <= sdi;
		dac_grab <= P2_DAC_SDO;
		amc_grab <= P2_AMC7823_SPI_MISO;
		sdc_grab <= P2_AD7794_DOUT;
	end

	// lmk has no read path here
	always_comb begin
		case (dev_sel)
			DEV_NONE, DEV_LMK: miso = 1'b0;
			DEV_ADC0, DEV_ADC1, DEV_ADC_BOTH: miso = adc_grab;
			DEV_DAC: miso = dac_grab;
			DEV_AMC: miso = amc_grab;
			DEV_SDC: miso = sdc_grab;
			default: miso = 1'b0;
		endcase
	end

endmodule

//--- llspi.sv
`timescale 1ns/1ps

module llspi #(
	parameter int pace_bits = llspi_board_pkg::PACE_BITS_DEFAULT,
	parameter int cmd_aw = llspi_board_pkg::CMD_AW_DEFAULT
) (
	input  logic                            clk,
	input  logic                            arst_n,
	// host side
	input  logic [llspi_cmd_pkg::CMD_W-1:0] host_din,
	input  logic                            host_we,
	input  logic                            result_re,
	output logic [7:0]                      host_result,
	output logic [7:0]                      status,
	// fast bus
	output logic                            P2_SCLK,
	output logic                            P2_SDI,
	output logic                            P2_LMK_LEuWire,
	output logic                            P2_ADC_SDIO_DIR,
	output logic                            P2_ADC_CSB_0,
	output logic                            P2_ADC_CSB_1,
	output logic                            P2_DAC_CSB,
	input  logic                            P2_DAC_SDO,
	// poll bus, isolated from the adc and dac lines
	output logic                            P2_POLL_SCLK,
	output logic                            P2_POLL_MOSI,
	output logic                            P2_AMC7823_SPI_SS,
	output logic                            P2_AD7794_CSb,
	input  logic                            P2_AMC7823_SPI_MISO,
	input  logic                            P2_AD7794_DOUT,
	// split adc sdio, buffer lives outside
	input  logic                            sdi,
	output logic                            sdo,
	output logic                            sdio_drive
);

	import llspi_board_pkg::*;
	import llspi_cmd_pkg::*;

	logic [CMD_W-1:0] cmd_data;
	logic cmd_empty;
	logic pull;
	logic sclk;
	logic mosi;
	logic miso;
	logic [CTL_W-1:0] ctl_bits;
	logic result_we;
	logic [7:0] result;
	logic [7:0] result_head;
	logic [RESULT_AW:0] result_count;

	// host command words, full-queue writes dropped
	spi_word_fifo #(.dw(CMD_W), .aw(cmd_aw)) cmd_fifo (
		.clk(clk), .arst_n(arst_n),
		.we(host_we), .din(host_din),
		.re(pull), .dout(cmd_data),
		.full(), .empty(cmd_empty), .count()
	);

	spi_eater #(.pace_bits(pace_bits)) eater (
		.clk(clk), .arst_n(arst_n),
		.cmd_data(cmd_data), .cmd_empty(cmd_empty), .pull(pull),
		.miso(miso), .sclk(sclk), .mosi(mosi), .ctl_bits(ctl_bits),
		.result_we(result_we), .result(result)
	);

	spi_pin_mux pins (
		.clk(clk), .arst_n(arst_n),
		.sclk(sclk), .mosi(mosi), .ctl_bits(ctl_bits),
		.P2_SCLK(P2_SCLK), .P2_SDI(P2_SDI), .P2_LMK_LEuWire(P2_LMK_LEuWire),
		.P2_ADC_SDIO_DIR(P2_ADC_SDIO_DIR),
		.P2_ADC_CSB_0(P2_ADC_CSB_0), .P2_ADC_CSB_1(P2_ADC_CSB_1),
		.P2_DAC_CSB(P2_DAC_CSB),
		.P2_POLL_SCLK(P2_POLL_SCLK), .P2_POLL_MOSI(P2_POLL_MOSI),
		.P2_AMC7823_SPI_SS(P2_AMC7823_SPI_SS), .P2_AD7794_CSb(P2_AD7794_CSb),
		.P2_DAC_SDO(P2_DAC_SDO), .P2_AMC7823_SPI_MISO(P2_AMC7823_SPI_MISO),
		.P2_AD7794_DOUT(P2_AD7794_DOUT),
		.sdi(sdi), .sdo(sdo), .sdio_drive(sdio_drive), .miso(miso)
	);

	// read-back bytes, a write into a full queue is lost
	spi_word_fifo #(.dw(8), .aw(RESULT_AW)) result_fifo (
		.clk(clk), .arst_n(arst_n),
		.we(result_we), .din(result),
		.re(result_re), .dout(result_head),
		.full(), .empty(), .count(result_count)
	);

	// host sees the head word latched on its read strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			host_result <= 8'hcc;
		end else if (result_re) begin
			host_result <= result_head;
		end
	end

	// count nibble wraps once 16 results are waiting
	assign status = {3'b000, cmd_empty, result_count[3:0]};

endmodule

//--- llspi_sva.sv
`timescale 1ns/1ps

module llspi_sva (
	input logic clk,
	input logic arst_n,
	input logic sclk_fast,
	input logic sclk_poll,
	input logic cs_lmk,
	input logic cs_adc0,
	input logic cs_adc1,
	input logic cs_dac,
	input logic cs_amc,
	input logic cs_sdc
);

	logic [5:0] cs_n;

	// selects in order lmk, adc0, adc1, dac, amc, sdc
	localparam logic [5:0] BOTH_ADC = 6'b011000;

	assign cs_n = {cs_lmk, cs_adc0, cs_adc1, cs_dac, cs_amc, cs_sdc};

	// one device at a time and both adcs only together
	a_one_select: assert property (@(posedge clk) disable iff (!arst_n)
		($countones(~cs_n) <= 1) || ((~cs_n) == BOTH_ADC))
		else $error("more than one chip select active outside the dual adc code");

	// the fast clock runs only while both poll parts are deselected
	a_fast_clock: assert property (@(posedge clk) disable iff (!arst_n)
		sclk_fast |-> (cs_amc && cs_sdc))
		else $error("fast serial clock high while a poll part was selected");

	// the poll clock runs only for a poll part
	// together with the check above the two clocks never overlap
	a_poll_clock: assert property (@(posedge clk) disable iff (!arst_n)
		sclk_poll |-> !(cs_amc && cs_sdc))
		else $error("poll serial clock high with no poll part selected");

	// no select change in the middle of a byte
	a_cs_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(sclk_fast || sclk_poll) |-> $stable(cs_n))
		else $error("chip select changed while a byte was shifting");

endmodule

bind spi_pin_mux llspi_sva pin_checks (
	.clk(clk), .arst_n(arst_n),
	.sclk_fast(P2_SCLK), .sclk_poll(P2_POLL_SCLK),
	.cs_lmk(P2_LMK_LEuWire), .cs_adc0(P2_ADC_CSB_0), .cs_adc1(P2_ADC_CSB_1),
	.cs_dac(P2_DAC_CSB), .cs_amc(P2_AMC7823_SPI_SS), .cs_sdc(P2_AD7794_CSb)
);

//--- tb_llspi.sv
`timescale 1ns/1ps

module tb_llspi;

	localparam int PACE_BITS = 2;
	// clock budget per record for the watchdog
	localparam int CYCLES_PER_RECORD = 40 * (1 << PACE_BITS);
	localparam int DRAIN_LIMIT = 8;
	// a byte is 16 ticks plus slack
	localparam int BYTE_LIMIT = 24 * (1 << PACE_BITS);

	logic clk;
	logic arst_n;
	logic [8:0] host_din;
	logic host_we;
	logic result_re;
	logic [7:0] host_result;
	logic [7:0] status;
	logic P2_SCLK, P2_SDI, P2_LMK_LEuWire, P2_ADC_SDIO_DIR;
	logic P2_ADC_CSB_0, P2_ADC_CSB_1, P2_DAC_CSB, P2_DAC_SDO;
	logic P2_POLL_SCLK, P2_POLL_MOSI, P2_AMC7823_SPI_SS, P2_AD7794_CSb;
	logic P2_AMC7823_SPI_MISO, P2_AD7794_DOUT;
	logic sdi, sdo, sdio_drive;

	// records from the data file
	logic [7:0] op_q[$];
	logic [8:0] val_q[$];
	int n_records = 0;
	int mismatch_cnt = 0;
	int other_cnt = 0;

	// bus monitor state
	logic fast_q = 1'b0;
	logic poll_q = 1'b0;
	logic [7:0] fast_byte = 8'h00;
	logic [7:0] poll_byte = 8'h00;
	logic [7:0] sdo_byte = 8'h00;
	int fast_rises = 0;
	int poll_rises = 0;
	int fast_base = 0;
	int poll_base = 0;

	// device reply byte sent msb first
	logic [7:0] reply_byte = 8'h00;
	logic [2:0] bit_idx = 3'd0;
	logic reply_bit;

	llspi #(.pace_bits(PACE_BITS)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// a selected part shifts out its reply bit
	// lines of idle parts are pulled high
	assign reply_bit = reply_byte[3'd7 - bit_idx];
	assign sdi = (!P2_ADC_CSB_0 || !P2_ADC_CSB_1) ? reply_bit : 1'b1;
	assign P2_DAC_SDO = !P2_DAC_CSB ? reply_bit : 1'b1;
	assign P2_AMC7823_SPI_MISO = !P2_AMC7823_SPI_SS ? reply_bit : 1'b1;
	assign P2_AD7794_DOUT = !P2_AD7794_CSb ? reply_bit : 1'b1;

	// pins move on the rising clock and are looked at half a period later
	always @(negedge clk) begin
		fast_q <= P2_SCLK;
		poll_q <= P2_POLL_SCLK;
		if (P2_SCLK && !fast_q) begin
			fast_byte <= {fast_byte[6:0], P2_SDI};
			sdo_byte <= {sdo_byte[6:0], sdo};
			fast_rises <= fast_rises + 1;
		end
		if (P2_POLL_SCLK && !poll_q) begin
			poll_byte <= {poll_byte[6:0], P2_POLL_MOSI};
			poll_rises <= poll_rises + 1;
		end
		// next reply bit after each serial clock fall
		// the index wraps every byte
		if ((!P2_SCLK && fast_q) || (!P2_POLL_SCLK && poll_q)) begin
			bit_idx <= bit_idx + 3'd1;
		end
	end

	task automatic check_value(input string name, input logic [8:0] got,
		input logic [8:0] exp);
		assert (got === exp) else begin
			mismatch_cnt++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic verify_rises(input string bus, input int got, input int exp);
		assert (got == exp) else begin
			other_cnt++;
			$display("%s bus serial clock rose %0d times, %0d expected", bus, got, exp);
		end
	endtask

	task automatic load_records();
		int fd;
		int n;
		logic [7:0] op;
		logic [8:0] val;
		logic [8*160-1:0] junk;
		fd = $fopen("llspi_testdata.txt", "r");
		if (fd == 0) begin
			other_cnt++;
			$display("cannot open llspi_testdata.txt");
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, " %c", op);
			if (n != 1) break;
			if (op == "#") begin
				n = $fgets(junk, fd);
			end else begin
				n = $fscanf(fd, "%h", val);
				if (n != 1) begin
					other_cnt++;
					$display("record of type %c has no value", op);
					break;
				end
				op_q.push_back(op);
				val_q.push_back(val);
			end
		end
		$fclose(fd);
	endtask

	function automatic bit byte_finished();
		return ((fast_rises - fast_base) + (poll_rises - poll_base) >= 8) &&
			!P2_SCLK && !P2_POLL_SCLK;
	endfunction

	task automatic send_word(input logic [8:0] word);
		int i;
		fast_base = fast_rises;
		poll_base = poll_rises;
		host_din = word;
		host_we = 1'b1;
		@(negedge clk);
		host_we = 1'b0;
		// the word is queued on this clock and cannot be pulled before the next one
		check_value("status[4]", {8'b0, status[4]}, 9'h000);
		// serializer pulls the word as soon as it is idle
		for (i = 0; i < DRAIN_LIMIT && !status[4]; i++) begin
			@(negedge clk);
		end
		assert (status[4]) else begin
			other_cnt++;
			$display("command queue did not drain after word %h", word);
		end
		// data words run eight serial clocks
		if (!word[8]) begin
			for (i = 0; i < BYTE_LIMIT && !byte_finished(); i++) begin
				@(negedge clk);
			end
		end
		// pins trail ctl_bits by a clock and the result count settles too
		repeat (2) @(negedge clk);
	endtask

	task automatic read_result(input logic [8:0] exp);
		result_re = 1'b1;
		@(negedge clk);
		result_re = 1'b0;
		check_value("host_result", {1'b0, host_result}, exp);
	endtask

	initial begin
		host_din = '0;
		host_we = 1'b0;
		result_re = 1'b0;
		arst_n = 1'b0;
		load_records();
		n_records = op_q.size();
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		foreach (op_q[i]) begin
			case (op_q[i])
				"w": send_word(val_q[i]);
				"r": reply_byte = val_q[i][7:0];
				"e": check_value("chip_select_pins", {3'b000, P2_LMK_LEuWire, P2_ADC_CSB_0,
					P2_ADC_CSB_1, P2_DAC_CSB, P2_AMC7823_SPI_SS, P2_AD7794_CSb}, val_q[i]);
				"f": begin
					verify_rises("fast", fast_rises - fast_base, 8);
					check_value("P2_SDI", {1'b0, fast_byte}, val_q[i]);
				end
				"p": begin
					// poll bytes leave P2_SCLK quiet
					verify_rises("poll", poll_rises - poll_base, 8);
					verify_rises("fast", fast_rises - fast_base, 0);
					check_value("P2_POLL_MOSI", {1'b0, poll_byte}, val_q[i]);
				end
				"o": check_value("sdo", {1'b0, sdo_byte}, val_q[i]);
				"s": check_value("status", {1'b0, status}, val_q[i]);
				"h": read_result(val_q[i]);
				"d": check_value("sdio_dir_drive", {7'b0, P2_ADC_SDIO_DIR, sdio_drive},
					val_q[i]);
				default: begin
					other_cnt++;
					$display("unknown record type %c in test data", op_q[i]);
				end
			endcase
		end
		$display("%0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// watchdog sized from the record count
	initial begin
		wait (n_records > 0);
		repeat (n_records * CYCLES_PER_RECORD) @(posedge clk);
		$display("watchdog expired before all records ran");
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- llspi.f
llspi_cmd_pkg.sv
llspi_board_pkg.sv
spi_word_fifo.sv
spi_eater.sv
spi_pin_mux.sv
llspi.sv
llspi_sva.sv
tb_llspi.sv

//--- Makefile
VERILATOR = verilator
TOP       = tb_llspi
FILELIST  = llspi.f
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = Done: errors found
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- llspi_testdata.txt
# op value(hex): w command word, r reply byte, e selects {lmk,adc0,adc1,dac,amc,sdc}
# f fast mosi byte, p poll mosi byte, o sdo byte, s status, h host_result, d {sdio_dir,drive}
e 3f
s 10
d 3
w 122
e 2f
d 3
r 3c
w 0a5
f a5
o a5
s 11
h 3c
s 10
w 133
e 37
d 0
r c3
w 05a
f 5a
o 5a
h c3
w 105
e 27
d 3
w 0f0
f f0
o f0
s 10
w 121
e 1f
r ff
w 081
f 81
o 00
s 11
h 00
w 124
e 3b
r 96
w 0c3
f c3
o 00
w 126
e 3d
r 5e
w 012
p 12
s 12
h 96
s 11
h 5e
s 10
w 127
e 3e
r a7
w 01e
p 1e
h a7
w 100
e 3f
s 10
